// File: sim.f
rtl/renamePkg.sv
rtl/activeListIf.sv
rtl/activeList.sv
rtl/freeList.sv
rtl/renameCommitter.sv
rtl/renameTop.sv
bench/renameTop_assert.sv
bench/renameTb.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := renameTb
FILELIST   := sim.f
OBJ_DIR    := obj_dir
LOG        := sim.log
LINT_FLAGS := --lint-only --timing --assert -Wall
SIM_FLAGS  := --binary --timing --assert -Wno-fatal -Mdir $(OBJ_DIR)
RUN_FLAGS  := +verilator+error+limit+1000
FAIL_MSG   := TESTBENCH FAILED
PASS_MSG   := TESTBENCH PASSED

.PHONY: lint build sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim: build
	./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation ended early, see $(LOG)"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: bench/renameTb.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for renameTop: clock, reset, random dispatch, commit and
// recovery, queue models of the active list and free list, error counts.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module renameTb;
    import renamePkg::*;

    localparam int STIM_CYCLES = 2000;
    // Stimulus plus reset, drain and margin.
    localparam int MAX_CYCLES = 3000;
    localparam int RECOVERY_LIMIT = 16;
    localparam bit [31:0] SEED = 32'hb33d8cb5;
    localparam int MODE_RANDOM = 0;
    localparam int MODE_DRAIN = 1;
    localparam int MODE_IDLE = 2;

    logic clk = 1'b0;
    logic rst;
    logic dispatchValid;
    logic dispatchWriteReg;
    PRegNum dispatchPrevReg;
    logic dispatchReady;
    PRegNum dispatchReg;
    AlIndex dispatchIndex;
    logic commit;
    LaneCount commitNum;
    logic recover;
    AlIndex recoverIndex;
    logic [COMMIT_WIDTH-1:0] releaseValid;
    PRegNum [COMMIT_WIDTH-1:0] releasedReg;
    logic inRecovery;
    LaneCount flushNum;
    AlCount alCount;
    FreeCount freeCount;

    // Model of the active list, oldest entry first.
    AlEntry alModel[$];
    AlIndex modelHead;
    PRegNum freeModel[$];
    // Released registers that the free list takes at the coming edge.
    PRegNum pendingFree[$];
    logic [COMMIT_WIDTH-1:0] expValid;
    PRegNum [COMMIT_WIDTH-1:0] expReg;

    bit recovering;
    int recoverAge;
    int recoverSlot;
    int expFlush;
    int flushTotal;
    int expAlCountAfter;
    int benchErrors;
    int timeouts;
    int cycleCount;

    always #50 clk = ~clk;

    renameTop u_dut (
        .clk              (clk),
        .rst              (rst),
        .dispatchValid    (dispatchValid),
        .dispatchWriteReg (dispatchWriteReg),
        .dispatchPrevReg  (dispatchPrevReg),
        .dispatchReady    (dispatchReady),
        .dispatchReg      (dispatchReg),
        .dispatchIndex    (dispatchIndex),
        .commit           (commit),
        .commitNum        (commitNum),
        .recover          (recover),
        .recoverIndex     (recoverIndex),
        .releaseValid     (releaseValid),
        .releasedReg      (releasedReg),
        .inRecovery       (inRecovery),
        .flushNum         (flushNum),
        .alCount          (alCount),
        .freeCount        (freeCount)
    );

    task automatic checkValue(input string testName, input int expected, input int actual);
        assert (expected == actual)
        else begin
            benchErrors++;
            $display("CHECK FAILED %s: expected %0d, actual %0d", testName, expected, actual);
        end
    endtask

    task automatic checkCondition(input bit condition, input string problem);
        assert (condition)
        else begin
            benchErrors++;
            $display("ERROR: %s", problem);
        end
    endtask

    task automatic printSummary();
        $display("Summary: %0d bench check errors, %0d assertion failures, %0d timeouts",
                 benchErrors, u_dut.u_assert.failCount, timeouts);
    endtask

    // Outputs registered at the last rising edge.
    task automatic checkState();
        int liveWriting;
        liveWriting = 0;
        foreach (alModel[i]) begin
            liveWriting += int'(alModel[i].writeReg);
        end
        checkValue("alCount", alModel.size(), alCount);
        checkValue("freeCount", freeModel.size(), freeCount);
        checkValue("releaseValid", expValid, releaseValid);
        if (expValid == '0) begin
            // Every register is free, held by a live op or architectural.
            checkValue("register balance", PHYS_REG_NUM - ARCH_REG_NUM,
                       int'(freeCount) + liveWriting);
        end
        for (int i = 0; i < COMMIT_WIDTH; i++) begin
            if (expValid[i]) begin
                checkValue("releasedReg", expReg[i], releasedReg[i]);
                pendingFree.push_back(expReg[i]);
            end
        end
        if (!recovering) begin
            checkValue("inRecovery idle", 0, inRecovery);
        end
        else if (recoverAge == 0) begin
            checkValue("inRecovery rise", 1, inRecovery);
        end
        else if (!inRecovery) begin
            checkValue("flushNum total", expFlush, flushTotal);
            checkValue("alCount after recovery", expAlCountAfter, alCount);
            recovering = 1'b0;
        end
        else if (recoverAge > RECOVERY_LIMIT) begin
            checkCondition(1'b0, "recovery did not end within the cycle limit");
            recovering = 1'b0;
        end
        recoverAge++;
    endtask

    task automatic driveInputs(input int mode, input int cycle);
        int commitPercent;
        dispatchValid = 1'b0;
        dispatchWriteReg = 1'b0;
        dispatchPrevReg = '0;
        commit = 1'b0;
        commitNum = '0;
        recover = 1'b0;
        recoverIndex = '0;
        // Slow and fast commit windows so the list both fills and empties.
        commitPercent = ((cycle / 250) % 2 == 0) ? 20 : 75;
        if (recovering || mode == MODE_IDLE) begin
            return;
        end
        if (mode == MODE_DRAIN) begin
            if (alModel.size() != 0) begin
                commit = 1'b1;
                commitNum = (alModel.size() >= 2) ? 2'd2 : 2'd1;
            end
        end
        else if (alModel.size() != 0 && ($urandom % 100) < 3) begin
            recoverSlot = $urandom % alModel.size();
            recover = 1'b1;
            recoverIndex = AlIndex'(int'(modelHead) + recoverSlot);
        end
        else begin
            dispatchValid = ($urandom % 100) < 70;
            dispatchWriteReg = ($urandom % 4) != 0;
            dispatchPrevReg = PRegNum'($urandom);
            if (alModel.size() != 0 && ($urandom % 100) < commitPercent) begin
                commit = 1'b1;
                commitNum = (alModel.size() >= 2 && $urandom % 2 == 1) ? 2'd2 : 2'd1;
            end
        end
    endtask

    // Mirrors what the DUT does at the coming rising edge.
    task automatic updateModel();
        bit readyExp;
        AlEntry e;
        expValid = '0;
        expReg = '0;
        readyExp = (alModel.size() < AL_DEPTH) && (freeModel.size() != 0) &&
                   !recovering && !recover;
        checkValue("dispatchReady", int'(readyExp), dispatchReady);
        if (commit) begin
            // Committed ops free the mapping they replaced, oldest first.
            for (int i = 0; i < int'(commitNum); i++) begin
                e = alModel.pop_front();
                expValid[i] = e.writeReg;
                expReg[i] = e.phyPrevDstReg;
            end
            modelHead = modelHead + AlIndex'(commitNum);
        end
        if (recovering && flushNum != '0) begin
            checkCondition(int'(flushNum) <= expFlush - flushTotal,
                           "flushNum exceeds the entries left to squash");
            // Squashed ops free their own register, youngest first.
            for (int i = 0; i < int'(flushNum) && alModel.size() != 0; i++) begin
                e = alModel.pop_back();
                expValid[i] = e.writeReg;
                expReg[i] = e.phyDstReg;
            end
            flushTotal += int'(flushNum);
        end
        if (recover) begin
            recovering = 1'b1;
            recoverAge = 0;
            flushTotal = 0;
            expFlush = alModel.size() - 1 - recoverSlot;
            expAlCountAfter = recoverSlot + 1;
        end
        if (dispatchValid && dispatchReady) begin
            checkValue("dispatchIndex", int'(AlIndex'(int'(modelHead) + alModel.size())),
                       dispatchIndex);
            e.writeReg = dispatchWriteReg;
            e.phyDstReg = '0;
            e.phyPrevDstReg = dispatchPrevReg;
            if (dispatchWriteReg) begin
                checkValue("dispatchReg", freeModel[0], dispatchReg);
                e.phyDstReg = freeModel.pop_front();
            end
            alModel.push_back(e);
        end
        while (pendingFree.size() != 0) begin
            freeModel.push_back(pendingFree.pop_front());
        end
    endtask

    task automatic stepCycle(input int mode, input int cycle);
        checkState();
        driveInputs(mode, cycle);
        #1;
        updateModel();
        @(negedge clk);
    endtask

    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount >= MAX_CYCLES) begin
            timeouts++;
            $display("ERROR: run stopped after %0d cycles without finishing", MAX_CYCLES);
            printSummary();
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    initial begin
        rst = 1'b1;
        dispatchValid = 1'b0;
        dispatchWriteReg = 1'b0;
        dispatchPrevReg = '0;
        commit = 1'b0;
        commitNum = '0;
        recover = 1'b0;
        recoverIndex = '0;
        modelHead = '0;
        expValid = '0;
        expReg = '0;
        void'($urandom(SEED));
        // Registers above the architectural set start out free.
        for (int i = ARCH_REG_NUM; i < PHYS_REG_NUM; i++) begin
            freeModel.push_back(PRegNum'(i));
        end
        repeat (10) @(negedge clk);
        rst = 1'b0;
        for (int cycle = 0; cycle < STIM_CYCLES; cycle++) begin
            stepCycle(MODE_RANDOM, cycle);
        end
        while (recovering || alModel.size() != 0) begin
            stepCycle(MODE_DRAIN, 0);
        end
        repeat (3) stepCycle(MODE_IDLE, 0);
        printSummary();
        if (benchErrors == 0 && u_dut.u_assert.failCount == 0) begin
            $display("TESTBENCH PASSED");
        end
        else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: bench/renameTop_assert.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Protocol assertions for renameTop and the bind that attaches them.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module renameTop_assert (
    input logic clk,
    input logic rst,
    input logic commit,
    input renamePkg::LaneCount commitNum,
    input logic recover,
    input logic inRecovery,
    input renamePkg::LaneCount flushNum,
    input renamePkg::AlCount alCount,
    input renamePkg::FreeCount freeCount
);
    import renamePkg::*;

    int failCount = 0;

    // Each tail step shrinks the active list by the lanes it flushed.
    walkShrinksList: assert property (@(posedge clk) disable iff (rst)
        flushNum != '0 |=> alCount == $past(alCount) - AlCount'($past(flushNum)))
    else begin
        failCount++;
        $error("active list did not shrink by flushNum during the tail walk");
    end

    recoverEntersRecovery: assert property (@(posedge clk) disable iff (rst)
        recover |-> !inRecovery ##1 inRecovery)
    else begin
        failCount++;
        $error("recover pulse did not start a recovery");
    end

    commitRules: assert property (@(posedge clk) disable iff (rst)
        commit |-> !inRecovery && commitNum != '0 && AlCount'(commitNum) <= alCount)
    else begin
        failCount++;
        $error("commit outside the allowed count or during recovery");
    end

    // Recovery ends only after a walk step with nothing left to flush.
    recoveryEndsIdle: assert property (@(posedge clk) disable iff (rst)
        $fell(inRecovery) |-> $past(flushNum) == '0)
    else begin
        failCount++;
        $error("recovery ended while entries were still being flushed");
    end

    // Neither list can hold more than its share of registers and slots.
    occupancyInRange: assert property (@(posedge clk) disable iff (rst)
        alCount <= AlCount'(AL_DEPTH) &&
        freeCount <= FreeCount'(PHYS_REG_NUM - ARCH_REG_NUM))
    else begin
        failCount++;
        $error("active list or free list occupancy out of range");
    end

endmodule

bind renameTop renameTop_assert u_assert (
    .clk           (clk),
    .rst           (rst),
    .commit        (commit),
    .commitNum     (commitNum),
    .recover       (recover),
    .inRecovery    (inRecovery),
    .flushNum      (flushNum),
    .alCount       (alCount),
    .freeCount     (freeCount)
);

// File: rtl/renameTop.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Rename release top level: active list, free list and committer,
// with dispatch gating and dispatch record assembly.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module renameTop (
    input  logic clk,
    input  logic rst,
    input  logic dispatchValid,
    input  logic dispatchWriteReg,
    input  renamePkg::PRegNum dispatchPrevReg,
    output logic dispatchReady,
    output renamePkg::PRegNum dispatchReg,
    output renamePkg::AlIndex dispatchIndex,
    input  logic commit,
    input  renamePkg::LaneCount commitNum,
    input  logic recover,
    input  renamePkg::AlIndex recoverIndex,
    output logic [renamePkg::COMMIT_WIDTH-1:0] releaseValid,
    output renamePkg::PRegNum [renamePkg::COMMIT_WIDTH-1:0] releasedReg,
    output logic inRecovery,
    output renamePkg::LaneCount flushNum,
    output renamePkg::AlCount alCount,
    output renamePkg::FreeCount freeCount
);
    import renamePkg::*;

    activeListIf alBus ();

    logic alFull;
    logic freeEmpty;
    logic dispatchFire;
    logic allocate;
    AlEntry dispatchEntry;

    // No dispatch while the tail is being walked or about to be.
    assign dispatchReady = !alFull && !freeEmpty && !alBus.inRecovery && !recover;
    assign dispatchFire = dispatchValid && dispatchReady;

    // Ops without a destination take a slot but no register.
    assign allocate = dispatchFire && dispatchWriteReg;

    always_comb begin
        dispatchEntry.writeReg = dispatchWriteReg;
        dispatchEntry.phyDstReg = dispatchReg;
        dispatchEntry.phyPrevDstReg = dispatchPrevReg;
    end

    activeList u_activeList (
        .clk           (clk),
        .rst           (rst),
        .al            (alBus.activeList),
        .dispatchValid (dispatchFire),
        .dispatchEntry (dispatchEntry),
        .recoverIndex  (recoverIndex),
        .recover       (recover),
        .dispatchIndex (dispatchIndex),
        .count         (alCount),
        .full          (alFull)
    );

    freeList u_freeList (
        .clk          (clk),
        .rst          (rst),
        .allocate     (allocate),
        .allocReg     (dispatchReg),
        .releaseValid (releaseValid),
        .releasedReg  (releasedReg),
        .count        (freeCount),
        .empty        (freeEmpty)
    );

    renameCommitter u_committer (
        .clk          (clk),
        .rst          (rst),
        .al           (alBus.committer),
        .commit       (commit),
        .commitNum    (commitNum),
        .recover      (recover),
        .releaseValid (releaseValid),
        .releasedReg  (releasedReg),
        .flushNum     (flushNum)
    );

    assign inRecovery = alBus.inRecovery;

endmodule

// File: rtl/renameCommitter.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Committer: commit and recovery phase FSM, release pipeline registers
// and active list pop control.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module renameCommitter (
    input  logic clk,
    input  logic rst,
    activeListIf.committer al,
    input  logic commit,
    input  renamePkg::LaneCount commitNum,
    input  logic recover,
    output logic [renamePkg::COMMIT_WIDTH-1:0] releaseValid,
    output renamePkg::PRegNum [renamePkg::COMMIT_WIDTH-1:0] releasedReg,
    output renamePkg::LaneCount flushNum
);
    import renamePkg::*;

    RecoveryPhase phase;
    RecoveryPhase nextPhase;

    // Entries still to be walked off the tail.
    AlCount recoveryCount;
    AlCount nextRecoveryCount;

    LaneCount releaseNum;
    logic [COMMIT_WIDTH-1:0] nextValid;
    PRegNum [COMMIT_WIDTH-1:0] nextReg;

    always_ff @(posedge clk) begin
        if (rst) begin
            phase <= PHASE_COMMIT;
            recoveryCount <= '0;
            releaseValid <= '0;
        end
        else begin
            phase <= nextPhase;
            recoveryCount <= nextRecoveryCount;
            releaseValid <= nextValid;
        end
    end

    always_ff @(posedge clk) begin
        releasedReg <= nextReg;
    end

    // Tail lanes used this cycle.
    assign releaseNum = (recoveryCount > AlCount'(COMMIT_WIDTH)) ?
                        LaneCount'(COMMIT_WIDTH) : LaneCount'(recoveryCount);

    // Phase FSM.
    always_comb begin
        nextPhase = phase;
        nextRecoveryCount = recoveryCount;
        if (recover) begin
            nextPhase = PHASE_RECOVER_0;
            nextRecoveryCount = '0;
        end
        else begin
            case (phase)
                PHASE_RECOVER_0: begin
                    // The active list has the younger-entry count ready by now.
                    nextPhase = PHASE_RECOVER_1;
                    nextRecoveryCount = al.recoveryEntryNum;
                end
                PHASE_RECOVER_1: begin
                    nextPhase = (recoveryCount == '0) ? PHASE_COMMIT : PHASE_RECOVER_1;
                    nextRecoveryCount = recoveryCount - AlCount'(releaseNum);
                end
                default: begin
                    nextPhase = phase;
                end
            endcase
        end
    end

    // Pop control and the registers to release.
    always_comb begin
        al.popHeadNum = '0;
        al.popTailNum = '0;
        flushNum = '0;
        nextValid = '0;
        for (int i = 0; i < COMMIT_WIDTH; i++) begin
            nextReg[i] = al.readData[i].phyPrevDstReg;
        end

        case (phase)
            PHASE_COMMIT: begin
                // Committed ops hand back the mapping they replaced.
                if (commit) begin
                    al.popHeadNum = commitNum;
                    for (int i = 0; i < COMMIT_WIDTH; i++) begin
                        nextValid[i] = (i < int'(commitNum)) && al.readData[i].writeReg;
                    end
                end
            end
            PHASE_RECOVER_1: begin
                // Squashed ops hand back their own new register.
                al.popTailNum = releaseNum;
                flushNum = releaseNum;
                for (int i = 0; i < COMMIT_WIDTH; i++) begin
                    nextValid[i] = (i < int'(releaseNum)) && al.readData[i].writeReg;
                    nextReg[i] = al.readData[i].phyDstReg;
                end
            end
            default: begin
                // Recover step 0 only waits for the count.
                nextValid = '0;
            end
        endcase
    end

    assign al.inRecovery = (phase != PHASE_COMMIT);

endmodule

// File: rtl/freeList.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Free list: FIFO of physical register numbers with one allocation and
// up to two releases per cycle.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module freeList (
    input  logic clk,
    input  logic rst,
    input  logic allocate,
    output renamePkg::PRegNum allocReg,
    input  logic [renamePkg::COMMIT_WIDTH-1:0] releaseValid,
    input  renamePkg::PRegNum [renamePkg::COMMIT_WIDTH-1:0] releasedReg,
    output renamePkg::FreeCount count,
    output logic empty
);
    import renamePkg::*;

    // One slot per physical register, so the FIFO never overflows.
    PRegNum slots [PHYS_REG_NUM];

    // Slot pointers share the register number width.
    PRegNum head;
    PRegNum tail;

    FreeCount pushNum;
    PRegNum [COMMIT_WIDTH-1:0] writeAddr;

    // Releases are packed in lane order behind the tail.
    always_comb begin
        pushNum = '0;
        for (int i = 0; i < COMMIT_WIDTH; i++) begin
            writeAddr[i] = tail + PRegNum'(pushNum);
            if (releaseValid[i]) begin
                pushNum = pushNum + FreeCount'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            head <= '0;
            tail <= PRegNum'(PHYS_REG_NUM - ARCH_REG_NUM);
            count <= FreeCount'(PHYS_REG_NUM - ARCH_REG_NUM);
        end
        else begin
            head <= head + PRegNum'(allocate);
            tail <= tail + PRegNum'(pushNum);
            count <= count + pushNum - FreeCount'(allocate);
        end
    end

    // Registers above the architectural set start out free, in ascending order.
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < PHYS_REG_NUM - ARCH_REG_NUM; i++) begin
                slots[i] <= PRegNum'(ARCH_REG_NUM + i);
            end
        end
        else begin
            for (int i = 0; i < COMMIT_WIDTH; i++) begin
                if (releaseValid[i]) begin
                    slots[writeAddr[i]] <= releasedReg[i];
                end
            end
        end
    end

    assign allocReg = slots[head];
    assign empty = (count == '0);

endmodule

// File: rtl/activeList.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Active list: circular buffer of rename records with dispatch push,
// head pop for commit, tail pop for recovery and a two-entry read window.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module activeList (
    input  logic clk,
    input  logic rst,
    activeListIf.activeList al,
    input  logic dispatchValid,
    input  renamePkg::AlEntry dispatchEntry,
    input  renamePkg::AlIndex recoverIndex,
    input  logic recover,
    output renamePkg::AlIndex dispatchIndex,
    output renamePkg::AlCount count,
    output logic full
);
    import renamePkg::*;

    AlEntry entries [AL_DEPTH];

    // Head is the oldest live slot, tail the next free one.
    AlIndex head;
    AlIndex tail;

    // Slot of the op that caused the misprediction.
    AlIndex recoveryIndex;

    AlCount nextCount;

    always_comb begin
        nextCount = count + AlCount'(dispatchValid);
        nextCount = nextCount - AlCount'(al.popHeadNum) - AlCount'(al.popTailNum);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            head <= '0;
            tail <= '0;
            count <= '0;
        end
        else begin
            head <= head + AlIndex'(al.popHeadNum);
            tail <= tail + AlIndex'(dispatchValid) - AlIndex'(al.popTailNum);
            count <= nextCount;
        end
    end

    // Record storage.
    always_ff @(posedge clk) begin
        if (dispatchValid) begin
            entries[tail] <= dispatchEntry;
        end
    end

    always_ff @(posedge clk) begin
        if (recover) begin
            recoveryIndex <= recoverIndex;
        end
    end

    // Read window.
    // In recovery lane 0 is the youngest entry, so the tail is walked backwards.
    always_comb begin
        for (int i = 0; i < COMMIT_WIDTH; i++) begin
            if (al.inRecovery) begin
                al.readData[i] = entries[AlIndex'(tail - AlIndex'(i) - 1'b1)];
            end
            else begin
                al.readData[i] = entries[AlIndex'(head + AlIndex'(i))];
            end
        end
    end

    // Entries between the faulting slot and the tail, the faulting op excluded.
    // Dispatch is held off during recovery, so the tail stays put.
    assign al.recoveryEntryNum = AlCount'(AlIndex'(tail - recoveryIndex - 1'b1));

    assign dispatchIndex = tail;
    assign full = (count == AlCount'(AL_DEPTH));

endmodule

// File: rtl/activeListIf.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Pop control and read window between the committer and the active list.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

interface activeListIf;
    import renamePkg::*;

    LaneCount popHeadNum;
    LaneCount popTailNum;
    logic inRecovery;

    // Head window in commit, tail window (youngest first) in recovery.
    AlEntry [COMMIT_WIDTH-1:0] readData;
    AlCount recoveryEntryNum;

    modport committer (
        output popHeadNum, popTailNum, inRecovery,
        input  readData, recoveryEntryNum
    );

    modport activeList (
        input  popHeadNum, popTailNum, inRecovery,
        output readData, recoveryEntryNum
    );

endinterface

// File: rtl/renamePkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared sizes, types and the committer phase encoding for the
// register-release side of the rename stage.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package renamePkg;

    // Commit and recovery lanes handled per cycle.
    localparam int COMMIT_WIDTH = 2;

    // Physical register file size.
    localparam int PHYS_REG_NUM = 32;

    // Registers 0 to 15 hold the architectural state at reset.
    localparam int ARCH_REG_NUM = 16;

    // Active list slots.
    localparam int AL_DEPTH = 16;

    typedef logic [4:0] PRegNum;
    typedef logic [3:0] AlIndex;

    // Occupancy needs one bit more than the index to reach a full list.
    typedef logic [4:0] AlCount;
    typedef logic [1:0] LaneCount;
    typedef logic [5:0] FreeCount;

    // One rename record held in the active list.
    typedef struct packed {
        logic   writeReg;
        PRegNum phyDstReg;
        PRegNum phyPrevDstReg;
    } AlEntry;

    typedef enum logic [1:0] {
        PHASE_COMMIT    = 2'd0,
        PHASE_RECOVER_0 = 2'd1,
        PHASE_RECOVER_1 = 2'd2
    } RecoveryPhase;

endpackage
